//--- hdl/kv_settings.svh
// key vault sizing
// entry count and entry depth of the key store, plus the widths of the
// key buffer and the message block buffer fed by the read path
`ifndef KV_SETTINGS_SVH
`define KV_SETTINGS_SVH

// number of entries held by the key store
`define KV_NUM_ENTRIES 8

// dwords per entry, one entry fills a whole message block
`define KV_ENTRY_DWORDS 32

// key buffer width in bits, 12 dwords
`define KV_KEY_WIDTH 384

// message block buffer width in bits, 32 dwords
`define KV_BLOCK_WIDTH 1024

`endif

//--- hdl/kv_defines_pkg.sv
// key vault shared types
// dword, index, offset, pad size and destination buffer types used by the
// store, the copy fsm and the destination buffers
`include "kv_settings.svh"

package kv_defines_pkg;

    // one word of an entry or of a destination buffer
    typedef logic [31:0] kv_dword_t;

    // selects one entry of the store
    typedef logic [$clog2(`KV_NUM_ENTRIES)-1:0] kv_entry_idx_t;

    // selects one dword inside an entry
    typedef logic [$clog2(`KV_ENTRY_DWORDS)-1:0] kv_offset_t;

    // block data size, stored as the dword count minus one
    typedef logic [4:0] kv_pad_size_t;

    // key buffer, dword 0 sits in the low bits
    typedef kv_dword_t [`KV_KEY_WIDTH/32-1:0] kv_key_t;

    // message block buffer, same dword ordering as the key
    typedef kv_dword_t [`KV_BLOCK_WIDTH/32-1:0] kv_block_t;

endpackage

//--- hdl/kv_fsm.sv
// key vault copy control
// walks one dword offset through a destination buffer, strobing writes of
// store data and, when padding is enabled, of generated pad dwords, then
// pulses done for one cycle and returns to idle
`timescale 1ns/10ps
`include "kv_settings.svh"

module kv_fsm #(
    parameter int DATA_WIDTH = `KV_KEY_WIDTH,
    parameter bit PAD = 1'b0,
    localparam int NUM_DWORDS = DATA_WIDTH / 32,
    localparam int OFFSET_W = $clog2(NUM_DWORDS)
) (
    input  logic                           clk,
    input  logic                           rst_b,
    input  logic                           start,
    input  kv_defines_pkg::kv_pad_size_t   pad_data_size,
    output logic [OFFSET_W-1:0]            read_offset,
    output logic                           write_en,
    output logic [OFFSET_W-1:0]            write_offset,
    output logic                           write_pad,
    output kv_defines_pkg::kv_dword_t      pad_data,
    output logic                           done
);
    import kv_defines_pkg::*;

    // the counter must hold the full block dword count, so it is sized for
    // the widest destination whatever this instance copies
    localparam int CNT_W = $clog2(`KV_BLOCK_WIDTH / 32) + 1;

    // the length dword only fits when the data leaves room past the
    // start-of-pad dword, which for a 32 dword block means sizes below 27
    localparam int LEN_LIMIT = NUM_DWORDS - 5;

    typedef enum logic [1:0] {
        S_IDLE = 2'b00,
        S_COPY = 2'b01,
        S_PAD  = 2'b11,
        S_DONE = 2'b10
    } state_e;

    state_e           state;
    state_e           state_nxt;
    logic [CNT_W-1:0] offset;
    logic [CNT_W-1:0] offset_nxt;
    kv_pad_size_t     size_q;
    logic [CNT_W-1:0] size_dwords;
    logic [CNT_W-1:0] data_dwords;
    kv_dword_t        pad_len;

    // size is captured with the start so a later change on the input
    // cannot reshape a copy in flight
    assign size_dwords = CNT_W'(size_q) + CNT_W'(1);

    // with padding the data part ends after size+1 dwords, clamped to the
    // destination, and without padding the whole destination is data
    always_comb begin
        data_dwords = CNT_W'(NUM_DWORDS);
        if (PAD && (size_dwords < CNT_W'(NUM_DWORDS))) begin
            data_dwords = size_dwords;
        end
    end

    // message length in bits plus one block of prefix
    assign pad_len = 32'(data_dwords) * 32'd32 + 32'd1024;

    // pad dword for the current offset
    // start-of-pad wins over the length when both land on the last dword
    always_comb begin
        pad_data = '0;
        if (offset == data_dwords) begin
            pad_data = 32'h8000_0000;
        end else if ((offset == CNT_W'(NUM_DWORDS - 1)) &&
                     (size_q < kv_pad_size_t'(LEN_LIMIT))) begin
            pad_data = pad_len;
        end
    end

    always_comb begin
        state_nxt  = state;
        offset_nxt = offset;
        write_en   = 1'b0;
        write_pad  = 1'b0;
        done       = 1'b0;
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_nxt = S_COPY;
                end
            end
            S_COPY: begin
                write_en   = 1'b1;
                offset_nxt = offset + CNT_W'(1);
                // a full size block skips the pad state altogether
                if (offset_nxt == CNT_W'(NUM_DWORDS)) begin
                    state_nxt = S_DONE;
                end else if (PAD && (offset_nxt == data_dwords)) begin
                    state_nxt = S_PAD;
                end
            end
            S_PAD: begin
                write_en   = 1'b1;
                write_pad  = 1'b1;
                offset_nxt = offset + CNT_W'(1);
                if (offset_nxt == CNT_W'(NUM_DWORDS)) begin
                    state_nxt = S_DONE;
                end
            end
            S_DONE: begin
                done       = 1'b1;
                offset_nxt = '0;
                state_nxt  = S_IDLE;
            end
            default: begin
                state_nxt  = S_IDLE;
                offset_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state  <= S_IDLE;
            offset <= '0;
            size_q <= '0;
        end else begin
            state  <= state_nxt;
            offset <= offset_nxt;
            if ((state == S_IDLE) && start) begin
                size_q <= pad_data_size;
            end
        end
    end

    // source and destination advance together, dword for dword
    assign read_offset  = offset[OFFSET_W-1:0];
    assign write_offset = offset[OFFSET_W-1:0];

endmodule

//--- hdl/kv_key_store.sv
// key vault entry store
// holds the entries written through the load port and serves two
// independent read ports, one for the key copy and one for the block copy
`timescale 1ns/10ps
`include "kv_settings.svh"

module kv_key_store #(
    localparam int KEY_OFFSET_W = $clog2(`KV_KEY_WIDTH / 32),
    localparam int BLOCK_OFFSET_W = $clog2(`KV_BLOCK_WIDTH / 32)
) (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            load_en,
    input  kv_defines_pkg::kv_entry_idx_t   load_entry,
    input  kv_defines_pkg::kv_offset_t      load_offset,
    input  kv_defines_pkg::kv_dword_t       load_data,
    input  logic                            key_start,
    input  kv_defines_pkg::kv_entry_idx_t   key_entry,
    input  logic                            key_busy,
    input  logic [KEY_OFFSET_W-1:0]         key_offset,
    output kv_defines_pkg::kv_dword_t       key_data,
    input  logic                            block_start,
    input  kv_defines_pkg::kv_entry_idx_t   block_entry,
    input  logic                            block_busy,
    input  logic [BLOCK_OFFSET_W-1:0]       block_offset,
    output kv_defines_pkg::kv_dword_t       block_data
);
    import kv_defines_pkg::*;

    kv_dword_t     mem [`KV_NUM_ENTRIES][`KV_ENTRY_DWORDS];
    kv_entry_idx_t key_idx;
    kv_entry_idx_t block_idx;

    // entries come up as zero so an early copy never reads stale contents
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int e = 0; e < `KV_NUM_ENTRIES; e++) begin
                for (int d = 0; d < `KV_ENTRY_DWORDS; d++) begin
                    mem[e][d] <= '0;
                end
            end
        end else if (load_en) begin
            mem[load_entry][load_offset] <= load_data;
        end
    end

    // each port holds its entry for the length of a copy
    // a start seen while the port's fsm is busy leaves the index alone
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            key_idx   <= '0;
            block_idx <= '0;
        end else begin
            if (key_start && !key_busy) begin
                key_idx <= key_entry;
            end
            if (block_start && !block_busy) begin
                block_idx <= block_entry;
            end
        end
    end

    // reads are combinational so the dword lands in the buffer in the
    // same cycle as the write strobe that asks for it
    assign key_data   = mem[key_idx][kv_offset_t'(key_offset)];
    assign block_data = mem[block_idx][block_offset];

endmodule

//--- hdl/kv_dest_buffer.sv
// key vault destination buffer
// collects the dwords of one copy, taking either store data or a pad
// dword per write, and flags the contents valid once the copy is done
`timescale 1ns/10ps

module kv_dest_buffer #(
    parameter type buf_t = kv_defines_pkg::kv_key_t,
    localparam int NUM_DWORDS = $bits(buf_t) / 32,
    localparam int OFFSET_W = $clog2(NUM_DWORDS)
) (
    input  logic                        clk,
    input  logic                        rst_b,
    input  logic                        write_en,
    input  logic [OFFSET_W-1:0]         write_offset,
    input  logic                        write_pad,
    input  kv_defines_pkg::kv_dword_t   src_data,
    input  kv_defines_pkg::kv_dword_t   pad_data,
    input  logic                        done,
    output buf_t                        buf_out,
    output logic                        valid
);
    import kv_defines_pkg::*;

    buf_t      buf_q;
    kv_dword_t write_data;
    logic      valid_q;

    // pad dwords replace store data from the start-of-pad dword onward
    assign write_data = write_pad ? pad_data : src_data;

    always_ff @(posedge clk) begin
        if (write_en) begin
            buf_q[write_offset] <= write_data;
        end
    end

    // the flag drops with the first write of a new copy and comes back
    // on the edge that closes the done cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid_q <= 1'b0;
        end else if (write_en) begin
            valid_q <= 1'b0;
        end else if (done) begin
            valid_q <= 1'b1;
        end
    end

    // masking with write_en takes valid low already in the cycle of the
    // first write rather than one cycle later
    assign valid   = valid_q & ~write_en;
    assign buf_out = buf_q;

endmodule

//--- hdl/kv_read_client.sv
// key vault read client
// copies one store entry into the key buffer and, independently, the
// leading dwords of an entry into a padded message block buffer
`timescale 1ns/10ps
`include "kv_settings.svh"

module kv_read_client (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            load_en,
    input  kv_defines_pkg::kv_entry_idx_t   load_entry,
    input  kv_defines_pkg::kv_offset_t      load_offset,
    input  kv_defines_pkg::kv_dword_t       load_data,
    input  logic                            key_start,
    input  kv_defines_pkg::kv_entry_idx_t   key_entry,
    input  logic                            block_start,
    input  kv_defines_pkg::kv_entry_idx_t   block_entry,
    input  kv_defines_pkg::kv_pad_size_t    block_size,
    output kv_defines_pkg::kv_key_t         key_out,
    output logic                            key_valid,
    output logic                            key_done,
    output kv_defines_pkg::kv_block_t       block_out,
    output logic                            block_valid,
    output logic                            block_done
);
    import kv_defines_pkg::*;

    localparam int KEY_OFFSET_W = $clog2(`KV_KEY_WIDTH / 32);
    localparam int BLOCK_OFFSET_W = $clog2(`KV_BLOCK_WIDTH / 32);

    // key copy path
    logic [KEY_OFFSET_W-1:0]   key_rd_offset;
    logic [KEY_OFFSET_W-1:0]   key_wr_offset;
    logic                      key_write_en;
    logic                      key_write_pad;
    kv_dword_t                 key_pad_data;
    kv_dword_t                 key_data;

    // block copy path
    logic [BLOCK_OFFSET_W-1:0] block_rd_offset;
    logic [BLOCK_OFFSET_W-1:0] block_wr_offset;
    logic                      block_write_en;
    logic                      block_write_pad;
    kv_dword_t                 block_pad_data;
    kv_dword_t                 block_data;

    kv_key_store u_store (
        .clk         (clk),
        .rst_b       (rst_b),
        .load_en     (load_en),
        .load_entry  (load_entry),
        .load_offset (load_offset),
        .load_data   (load_data),
        .key_start   (key_start),
        .key_entry   (key_entry),
        // an fsm is out of idle exactly while it writes or signals done
        .key_busy    (key_write_en | key_done),
        .key_offset  (key_rd_offset),
        .key_data    (key_data),
        .block_start (block_start),
        .block_entry (block_entry),
        .block_busy  (block_write_en | block_done),
        .block_offset(block_rd_offset),
        .block_data  (block_data)
    );

    // the key copy never pads, so its size input is tied off
    kv_fsm #(.DATA_WIDTH(`KV_KEY_WIDTH), .PAD(1'b0)) u_key_fsm (
        .clk(clk), .rst_b(rst_b), .start(key_start),
        .pad_data_size(kv_pad_size_t'(0)), .read_offset(key_rd_offset),
        .write_en(key_write_en), .write_offset(key_wr_offset),
        .write_pad(key_write_pad), .pad_data(key_pad_data), .done(key_done)
    );

    kv_fsm #(.DATA_WIDTH(`KV_BLOCK_WIDTH), .PAD(1'b1)) u_block_fsm (
        .clk(clk), .rst_b(rst_b), .start(block_start),
        .pad_data_size(block_size), .read_offset(block_rd_offset),
        .write_en(block_write_en), .write_offset(block_wr_offset),
        .write_pad(block_write_pad), .pad_data(block_pad_data), .done(block_done)
    );

    kv_dest_buffer #(.buf_t(kv_key_t)) u_key_buf (
        .clk(clk), .rst_b(rst_b), .write_en(key_write_en),
        .write_offset(key_wr_offset), .write_pad(key_write_pad),
        .src_data(key_data), .pad_data(key_pad_data), .done(key_done),
        .buf_out(key_out), .valid(key_valid)
    );

    kv_dest_buffer #(.buf_t(kv_block_t)) u_block_buf (
        .clk(clk), .rst_b(rst_b), .write_en(block_write_en),
        .write_offset(block_wr_offset), .write_pad(block_write_pad),
        .src_data(block_data), .pad_data(block_pad_data), .done(block_done),
        .buf_out(block_out), .valid(block_valid)
    );

endmodule

//--- testbench/kv_read_client_asserts.sv
// key vault read client timing checks
// bound into the top level, watches the start to done schedule of both
// copy paths and the valid flags around each copy
`timescale 1ns/10ps

module kv_read_client_asserts (
    input logic clk,
    input logic rst_b,
    input logic key_start,
    input logic key_write_en,
    input logic key_done,
    input logic key_valid,
    input logic block_start,
    input logic block_write_en,
    input logic block_done,
    input logic block_valid
);
    // failed assertions so far, the testbench polls this count
    int unsigned fail_count = 0;

    logic key_idle;
    logic block_idle;

    // an fsm is out of idle exactly while it writes or signals done
    assign key_idle   = !(key_write_en || key_done);
    assign block_idle = !(block_write_en || block_done);

    // nothing is done or valid while reset is held and on the cycle after
    reset_quiet: assert property (@(posedge clk) (!rst_b || !$past(rst_b))
        |-> !(key_done || block_done || key_valid || block_valid))
        else begin
            fail_count++;
            $error("done or valid was high during or right after reset");
        end

    // an accepted start leads to a write on the very next cycle
    key_accept: assert property (@(posedge clk) disable iff (!rst_b)
        (key_start && key_idle) |=> key_write_en)
        else begin
            fail_count++;
            $error("key copy did not begin writing after an accepted start");
        end

    // 12 writes plus the done cycle take done low on the 13th edge after
    // the start edge, and the sampled fall shows up one tick after that
    key_done_time: assert property (@(posedge clk) disable iff (!rst_b)
        $fell(key_done) |-> $past(key_start && key_idle, 14))
        else begin
            fail_count++;
            $error("key_done did not fall 13 cycles after an accepted key_start");
        end

    key_valid_low: assert property (@(posedge clk) disable iff (!rst_b)
        (key_write_en || key_done) |-> !key_valid)
        else begin
            fail_count++;
            $error("key_valid was high while the key copy was running");
        end

    key_valid_set: assert property (@(posedge clk) disable iff (!rst_b)
        $past(key_done) |-> key_valid)
        else begin
            fail_count++;
            $error("key_valid did not rise on the cycle after key_done");
        end

    block_accept: assert property (@(posedge clk) disable iff (!rst_b)
        (block_start && block_idle) |=> block_write_en)
        else begin
            fail_count++;
            $error("block copy did not begin writing after an accepted start");
        end

    // the block always takes 32 writes whatever its data size, so done goes
    // low on the 33rd edge and the sampled fall is seen one tick later
    block_done_time: assert property (@(posedge clk) disable iff (!rst_b)
        $fell(block_done) |-> $past(block_start && block_idle, 34))
        else begin
            fail_count++;
            $error("block_done did not fall 33 cycles after an accepted block_start");
        end

    block_valid_low: assert property (@(posedge clk) disable iff (!rst_b)
        (block_write_en || block_done) |-> !block_valid)
        else begin
            fail_count++;
            $error("block_valid was high while the block copy was running");
        end

    block_valid_set: assert property (@(posedge clk) disable iff (!rst_b)
        $past(block_done) |-> block_valid)
        else begin
            fail_count++;
            $error("block_valid did not rise on the cycle after block_done");
        end

endmodule

bind kv_read_client kv_read_client_asserts u_asserts (
    .clk           (clk),
    .rst_b         (rst_b),
    .key_start     (key_start),
    .key_write_en  (key_write_en),
    .key_done      (key_done),
    .key_valid     (key_valid),
    .block_start   (block_start),
    .block_write_en(block_write_en),
    .block_done    (block_done),
    .block_valid   (block_valid)
);

//--- testbench/kv_read_client_tb.sv
// key vault read client testbench
// fills the store with random dwords, runs key and padded block copies
// alone, side by side and with a stray start, and compares both buffers
// with a model of the store and of the padding rule
`timescale 1ns/10ps
`include "kv_settings.svh"

module kv_read_client_tb;
    import kv_defines_pkg::*;

    // loading takes 256 cycles and each of the eleven copies stays under
    // 40, so about 700 cycles are needed in all
    localparam int MAX_CYCLES = 2000;

    logic          clk;
    logic          rst_b;
    logic          load_en;
    kv_entry_idx_t load_entry;
    kv_offset_t    load_offset;
    kv_dword_t     load_data;
    logic          key_start;
    kv_entry_idx_t key_entry;
    logic          block_start;
    kv_entry_idx_t block_entry;
    kv_pad_size_t  block_size;
    kv_key_t       key_out;
    logic          key_valid;
    logic          key_done;
    kv_block_t     block_out;
    logic          block_valid;
    logic          block_done;

    // copy of what the store should hold
    kv_dword_t   model [`KV_NUM_ENTRIES][`KV_ENTRY_DWORDS];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          block_sizes [6] = '{0, 5, 26, 27, 30, 31};

    kv_read_client uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int next_entry();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[2:0]);
    endfunction

    // data for dwords 0..size, then the start-of-pad dword, zero fill and
    // the length in bits plus 1024 in the last dword when it fits
    function automatic kv_dword_t expected_block_dword(input int entry, input int size,
                                                       input int idx);
        if (size == 31 || idx <= size) begin
            return model[entry][idx];
        end
        if (idx == size + 1) begin
            return 32'h8000_0000;
        end
        if (idx == 31 && size < 27) begin
            return 32'((size + 1) * 32 + 1024);
        end
        return '0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input kv_dword_t exp, input kv_dword_t act);
        assert (act === exp) else
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    // bounds the run and picks up any failed timing assertion
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (uut.u_asserts.fail_count != 0) begin
            abort_run("a timing assertion on the read client failed");
        end else if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout, tests still running after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic load_store();
        for (int e = 0; e < `KV_NUM_ENTRIES; e++) begin
            for (int d = 0; d < `KV_ENTRY_DWORDS; d++) begin
                @(negedge clk);
                rng_state   = xorshift32(rng_state);
                load_en     = 1'b1;
                load_entry  = kv_entry_idx_t'(e);
                load_offset = kv_offset_t'(d);
                load_data   = rng_state;
                model[e][d] = rng_state;
            end
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic start_key(input int entry);
        @(negedge clk);
        key_start = 1'b1;
        key_entry = kv_entry_idx_t'(entry);
        @(negedge clk);
        key_start = 1'b0;
    endtask

    task automatic start_block(input int entry, input int size);
        @(negedge clk);
        block_start = 1'b1;
        block_entry = kv_entry_idx_t'(entry);
        block_size  = kv_pad_size_t'(size);
        @(negedge clk);
        block_start = 1'b0;
    endtask

    // returns on the cycle after done, when the buffer is complete
    task automatic wait_key_result();
        while (!key_done) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic wait_block_result();
        while (!block_done) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_key(input string name, input int entry);
        check_value({name, " valid"}, 32'd1, 32'(key_valid));
        for (int i = 0; i < `KV_KEY_WIDTH / 32; i++) begin
            check_value($sformatf("%s dword %0d", name, i), model[entry][i], key_out[i]);
        end
    endtask

    task automatic check_block(input string name, input int entry, input int size);
        check_value({name, " valid"}, 32'd1, 32'(block_valid));
        for (int i = 0; i < `KV_BLOCK_WIDTH / 32; i++) begin
            check_value($sformatf("%s dword %0d", name, i),
                        expected_block_dword(entry, size, i), block_out[i]);
        end
    endtask

    initial begin
        int ke;
        int be;
        rng_state   = 32'd73;
        rst_b       = 1'b1;
        load_en     = 1'b0;
        load_entry  = '0;
        load_offset = '0;
        load_data   = '0;
        key_start   = 1'b0;
        key_entry   = '0;
        block_start = 1'b0;
        block_entry = '0;
        block_size  = '0;
        // a falling edge just after time zero fires the asynchronous reset
        #1 rst_b = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;

        load_store();

        ke = next_entry();
        start_key(ke);
        wait_key_result();
        check_key("key copy", ke);

        foreach (block_sizes[s]) begin
            be = next_entry();
            start_block(be, block_sizes[s]);
            wait_block_result();
            check_block($sformatf("block size %0d", block_sizes[s]), be, block_sizes[s]);
        end

        // both paths run at once on different entries
        ke = next_entry();
        be = (ke + 3) % `KV_NUM_ENTRIES;
        @(negedge clk);
        key_start   = 1'b1;
        key_entry   = kv_entry_idx_t'(ke);
        block_start = 1'b1;
        block_entry = kv_entry_idx_t'(be);
        block_size  = kv_pad_size_t'(12);
        @(negedge clk);
        key_start   = 1'b0;
        block_start = 1'b0;
        wait_key_result();
        check_key("parallel key", ke);
        wait_block_result();
        check_block("parallel block", be, 12);

        // a second start in the middle of a copy must change nothing
        ke = next_entry();
        start_key(ke);
        repeat (4) @(negedge clk);
        start_key((ke + 1) % `KV_NUM_ENTRIES);
        wait_key_result();
        check_key("stray start key", ke);

        be = next_entry();
        start_block(be, 10);
        repeat (8) @(negedge clk);
        start_block((be + 5) % `KV_NUM_ENTRIES, 3);
        wait_block_result();
        check_block("stray start block", be, 10);

        // let the last assertions sample before the verdict
        repeat (3) @(negedge clk);
        if (uut.u_asserts.fail_count != 0) begin
            abort_run("a timing assertion on the read client failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+hdl
hdl/kv_defines_pkg.sv
hdl/kv_fsm.sv
hdl/kv_key_store.sv
hdl/kv_dest_buffer.sv
hdl/kv_read_client.sv
testbench/kv_read_client_asserts.sv
testbench/kv_read_client_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the key vault read client testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module kv_read_client_tb -o kv_read_client_sim

# assertion errors are counted by the testbench, so they must not end the run early
sim_output=$(./obj_dir/kv_read_client_sim +verilator+error+limit+1000 || true)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qxF 'Done: no errors'; then
    exit 0
fi
exit 1
